//--- hw/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// data path word width
`define EXE_DATA_BITS 32

// register file address width
`define EXE_REG_BITS 5

// width of a shift amount and of the sa field in the instruction
`define EXE_SHAMT_BITS 5

`endif

//--- hw/exe_ctrl_pkg.sv
`include "exe_defines.svh"

package exe_ctrl_pkg;

	// alu opcodes numbered without gaps
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_NOR = 4'd5,
		ALU_SLT = 4'd6,
		ALU_LUI = 4'd7,
		ALU_SLL = 4'd8,  // shifter ops from here on
		ALU_SRL = 4'd9,
		ALU_SRA = 4'd10
	} alu_op_e;

	// operand a source
	typedef enum logic [1:0] {
		A_RS   = 2'd0,  // forwarded rs
		A_SA   = 2'd1,  // inst[10:6]
		A_LINK = 2'd2   // link address
	} a_src_e;

	// operand b source
	typedef enum logic [1:0] {
		B_RT   = 2'd0,  // forwarded rt
		B_IMM  = 2'd1,  // extended immediate
		B_FOUR = 2'd2,  // link target skips the delay slot
		B_ZERO = 2'd3
	} b_src_e;

	typedef logic [`EXE_SHAMT_BITS-1:0] shamt_t;

endpackage

//--- hw/exe_data_pkg.sv
`include "exe_defines.svh"

package exe_data_pkg;

	// bundle registered at the id/exe boundary
	typedef struct packed {
		logic valid;
		logic [`EXE_DATA_BITS-1:0] inst;
		logic [`EXE_DATA_BITS-1:0] link_addr;
		logic [`EXE_DATA_BITS-1:0] data_rs;  // already forwarded
		logic [`EXE_DATA_BITS-1:0] data_rt;
		exe_ctrl_pkg::a_src_e a_src;
		exe_ctrl_pkg::b_src_e b_src;
		exe_ctrl_pkg::alu_op_e alu_op;
		logic is_signed;
		logic imm_ext;  // 1 means sign extend
		logic [`EXE_REG_BITS-1:0] regw_addr;
		logic wb_wen;
	} id_exe_t;

	typedef struct packed {
		logic [`EXE_DATA_BITS-1:0] opa;
		logic [`EXE_DATA_BITS-1:0] opb;
	} operand_t;

	// bundle handed to the mem stage
	typedef struct packed {
		logic valid;
		logic [`EXE_DATA_BITS-1:0] result;
		logic [`EXE_DATA_BITS-1:0] store_data;  // rt value for stores
		logic overflow;
		logic [`EXE_REG_BITS-1:0] regw_addr;
		logic wb_wen;
	} exe_mem_t;

endpackage

//--- hw/operand_select.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module operand_select (
	input exe_data_pkg::id_exe_t id_in,
	output exe_data_pkg::operand_t operands
	);

	localparam int IMM_BITS = 16;
	localparam int SA_LSB = 6;

	exe_ctrl_pkg::shamt_t shamt;
	logic [IMM_BITS-1:0] imm_raw;
	logic [`EXE_DATA_BITS-1:0] imm_full;

	// fields pulled out of the instruction word
	assign shamt = id_in.inst[SA_LSB +: `EXE_SHAMT_BITS];
	assign imm_raw = id_in.inst[IMM_BITS-1:0];

	always_comb begin
		if (id_in.imm_ext) begin
			imm_full = {{(`EXE_DATA_BITS-IMM_BITS){imm_raw[IMM_BITS-1]}}, imm_raw};
		end
		else begin
			imm_full = {{(`EXE_DATA_BITS-IMM_BITS){1'b0}}, imm_raw};
		end
	end

	always_comb begin
		case (id_in.a_src)
			exe_ctrl_pkg::A_RS: operands.opa = id_in.data_rs;
			exe_ctrl_pkg::A_SA: begin
				operands.opa = {{(`EXE_DATA_BITS-`EXE_SHAMT_BITS){1'b0}}, shamt};
			end
			exe_ctrl_pkg::A_LINK: operands.opa = id_in.link_addr;
			default: operands.opa = id_in.data_rs;  // unused code falls back to rs
		endcase
	end

	always_comb begin
		case (id_in.b_src)
			exe_ctrl_pkg::B_RT: operands.opb = id_in.data_rt;
			exe_ctrl_pkg::B_IMM: operands.opb = imm_full;
			exe_ctrl_pkg::B_FOUR: operands.opb = `EXE_DATA_BITS'(4);  // link + 4
			exe_ctrl_pkg::B_ZERO: operands.opb = '0;
			default: operands.opb = id_in.data_rt;
		endcase
	end

endmodule

//--- hw/alu_core.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module alu_core (
	input exe_data_pkg::operand_t operands,
	input exe_ctrl_pkg::alu_op_e alu_op,
	input logic is_signed,
	output logic [`EXE_DATA_BITS-1:0] alu_result,
	output logic alu_overflow
	);

	localparam int MSB = `EXE_DATA_BITS - 1;
	localparam int HALF = `EXE_DATA_BITS / 2;

	logic [`EXE_DATA_BITS-1:0] a;
	logic [`EXE_DATA_BITS-1:0] b;
	logic [`EXE_DATA_BITS-1:0] sum;
	logic [`EXE_DATA_BITS-1:0] diff;
	logic add_wrap;
	logic sub_wrap;
	logic less;

	assign a = operands.opa;
	assign b = operands.opb;
	assign sum = a + b;
	assign diff = a - b;

	// same signs in, different sign out
	assign add_wrap = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	// opposite signs in, result takes sign of b
	assign sub_wrap = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	always_comb begin
		if (is_signed) begin
			less = $signed(a) < $signed(b);
		end
		else begin
			less = a < b;
		end
	end

	always_comb begin
		case (alu_op)
			exe_ctrl_pkg::ALU_ADD: alu_result = sum;
			exe_ctrl_pkg::ALU_SUB: alu_result = diff;
			exe_ctrl_pkg::ALU_AND: alu_result = a & b;
			exe_ctrl_pkg::ALU_OR: alu_result = a | b;
			exe_ctrl_pkg::ALU_XOR: alu_result = a ^ b;
			exe_ctrl_pkg::ALU_NOR: alu_result = ~(a | b);
			exe_ctrl_pkg::ALU_SLT: alu_result = {{MSB{1'b0}}, less};
			exe_ctrl_pkg::ALU_LUI: alu_result = {b[HALF-1:0], {HALF{1'b0}}};
			default: alu_result = '0;  // shifts are not ours
		endcase
	end

	always_comb begin
		case (alu_op)
			exe_ctrl_pkg::ALU_ADD: alu_overflow = is_signed & add_wrap;
			exe_ctrl_pkg::ALU_SUB: alu_overflow = is_signed & sub_wrap;
			default: alu_overflow = 1'b0;
		endcase
	end

endmodule

//--- hw/shift_unit.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module shift_unit (
	input exe_data_pkg::operand_t operands,
	input exe_ctrl_pkg::alu_op_e alu_op,
	output logic [`EXE_DATA_BITS-1:0] shift_result
	);

	exe_ctrl_pkg::shamt_t shamt;
	logic [`EXE_DATA_BITS-1:0] value;

	// only the low bits of a count
	assign shamt = operands.opa[`EXE_SHAMT_BITS-1:0];
	assign value = operands.opb;

	always_comb begin
		case (alu_op)
			exe_ctrl_pkg::ALU_SLL: shift_result = value << shamt;
			exe_ctrl_pkg::ALU_SRL: shift_result = value >> shamt;
			exe_ctrl_pkg::ALU_SRA: begin
				shift_result = $unsigned($signed(value) >>> shamt);  // keeps sign
			end
			default: shift_result = '0;
		endcase
	end

endmodule

//--- hw/exe_result.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_result (
	input logic clk,
	input logic exe_rst,
	input logic exe_en,
	input exe_data_pkg::id_exe_t id_in,
	input logic [`EXE_DATA_BITS-1:0] alu_result,
	input logic alu_overflow,
	input logic [`EXE_DATA_BITS-1:0] shift_result,
	output exe_data_pkg::exe_mem_t exe_out
	);

	logic [`EXE_DATA_BITS-1:0] unit_result;
	exe_data_pkg::exe_mem_t next_out;

	// pick the unit named by the opcode
	always_comb begin
		case (id_in.alu_op)
			exe_ctrl_pkg::ALU_SLL,
			exe_ctrl_pkg::ALU_SRL,
			exe_ctrl_pkg::ALU_SRA: unit_result = shift_result;
			default: unit_result = alu_result;
		endcase
	end

	always_comb begin
		next_out.valid = id_in.valid;
		next_out.result = unit_result;
		next_out.store_data = id_in.data_rt;
		next_out.overflow = alu_overflow;
		next_out.regw_addr = id_in.regw_addr;
		next_out.wb_wen = id_in.wb_wen & ~alu_overflow;  // no writeback on overflow
	end

	always_ff @(posedge clk) begin
		if (exe_rst) begin
			exe_out <= '0;
		end
		else if (exe_en) begin
			exe_out <= next_out;
		end
	end

endmodule

//--- hw/exe_stage.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_stage (
	input logic clk,
	input logic exe_rst,
	input logic exe_en,
	input exe_data_pkg::id_exe_t id_in,
	output exe_data_pkg::exe_mem_t exe_out
	);

	exe_data_pkg::operand_t operands;
	logic [`EXE_DATA_BITS-1:0] alu_result;
	logic alu_overflow;
	logic [`EXE_DATA_BITS-1:0] shift_result;

	operand_select opsel (
		.id_in(id_in),
		.operands(operands)
		);

	// both units see the same operands
	alu_core alu (
		.operands(operands),
		.alu_op(id_in.alu_op),
		.is_signed(id_in.is_signed),
		.alu_result(alu_result),
		.alu_overflow(alu_overflow)
		);

	shift_unit shifter (
		.operands(operands),
		.alu_op(id_in.alu_op),
		.shift_result(shift_result)
		);

	exe_result result (
		.clk(clk),
		.exe_rst(exe_rst),
		.exe_en(exe_en),
		.id_in(id_in),
		.alu_result(alu_result),
		.alu_overflow(alu_overflow),
		.shift_result(shift_result),
		.exe_out(exe_out)
		);

endmodule

//--- tb/exe_stage_tb.sv
`timescale 1ns/100ps
`include "exe_defines.svh"

module exe_stage_tb;

	localparam int RST_CYCLES = 16;
	localparam int ALU_CYCLES = 400;
	localparam int SRC_CYCLES = 300;
	localparam int OVF_CYCLES = 200;
	localparam int STALL_CYCLES = 250;
	localparam int MID_RST_CYCLES = 2;
	localparam int TEST_CYCLES = ALU_CYCLES + SRC_CYCLES + OVF_CYCLES + STALL_CYCLES
		+ 2 * MID_RST_CYCLES;
	localparam longint MAX_S = 64'sh0000_0000_7fff_ffff;  // largest signed 32-bit value
	localparam longint MIN_S = -MAX_S - 1;

	logic clk = 1'b0;
	logic exe_rst;
	logic exe_en;
	exe_data_pkg::id_exe_t id_in;
	exe_data_pkg::exe_mem_t exe_out;
	exe_data_pkg::exe_mem_t expected;  // model state updated on enabled edges
	logic [31:0] lfsr = 32'h2c02_452e;
	int errors = 0;
	int checks = 0;

	exe_stage DUT (
		.clk(clk),
		.exe_rst(exe_rst),
		.exe_en(exe_en),
		.id_in(id_in),
		.exe_out(exe_out)
		);

	always #4 clk = ~clk;

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// values near the signed limits
	function automatic logic [31:0] edge_value();
		case (rand_bits(3))
			0: return 32'h7fff_ffff;
			1: return 32'h8000_0000;
			2: return 32'hffff_ffff;
			3: return 32'h0000_0001;
			4: return 32'h7fff_0000 + rand_bits(16);
			5: return 32'h8000_0000 + rand_bits(8);
			default: return rand_bits(32);
		endcase
	endfunction

	// mode 0 alu ops, 1 operand sources, 2 overflow, 3 stall
	function automatic exe_data_pkg::id_exe_t make_bundle(input int mode);
		exe_data_pkg::id_exe_t b;
		b.valid = rand_bits(1);
		b.inst = rand_bits(32);
		b.link_addr = rand_bits(32);
		b.data_rs = rand_bits(32);
		b.data_rt = rand_bits(32);
		b.a_src = exe_ctrl_pkg::a_src_e'(rand_bits(2) % 3);
		b.b_src = exe_ctrl_pkg::b_src_e'(rand_bits(2));
		b.alu_op = exe_ctrl_pkg::alu_op_e'(rand_bits(4) % 11);
		b.is_signed = rand_bits(1);
		b.imm_ext = rand_bits(1);
		b.regw_addr = rand_bits(`EXE_REG_BITS);
		b.wb_wen = rand_bits(1);
		if (mode == 0) begin
			b.a_src = exe_ctrl_pkg::A_RS;
			b.b_src = exe_ctrl_pkg::B_RT;
		end
		else if (mode == 1 && rand_bits(2) == 0) begin
			b.a_src = exe_ctrl_pkg::A_LINK;  // link address plus four
			b.b_src = exe_ctrl_pkg::B_FOUR;
			b.alu_op = exe_ctrl_pkg::ALU_ADD;
		end
		else if (mode == 2) begin
			b.a_src = exe_ctrl_pkg::A_RS;
			b.b_src = exe_ctrl_pkg::B_RT;
			b.alu_op = rand_bits(1) ? exe_ctrl_pkg::ALU_SUB : exe_ctrl_pkg::ALU_ADD;
			b.data_rs = edge_value();
			b.data_rt = edge_value();
		end
		return b;
	endfunction

	// expected exe/mem bundle for one input bundle
	function automatic exe_data_pkg::exe_mem_t model_out(input exe_data_pkg::id_exe_t b);
		exe_data_pkg::exe_mem_t o;
		logic [31:0] a;
		logic [31:0] bb;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0] sh;
		longint wide;
		logic ovf;
		imm = b.imm_ext ? {{16{b.inst[15]}}, b.inst[15:0]} : {16'h0000, b.inst[15:0]};
		case (b.a_src)
			exe_ctrl_pkg::A_SA: a = {27'd0, b.inst[10:6]};
			exe_ctrl_pkg::A_LINK: a = b.link_addr;
			default: a = b.data_rs;
		endcase
		case (b.b_src)
			exe_ctrl_pkg::B_IMM: bb = imm;
			exe_ctrl_pkg::B_FOUR: bb = 32'd4;
			exe_ctrl_pkg::B_ZERO: bb = 32'd0;
			default: bb = b.data_rt;
		endcase
		sh = a[4:0];
		ovf = 1'b0;
		res = '0;
		case (b.alu_op)
			exe_ctrl_pkg::ALU_ADD: begin
				res = a + bb;
				wide = longint'($signed(a)) + longint'($signed(bb));
				ovf = b.is_signed && (wide > MAX_S || wide < MIN_S);
			end
			exe_ctrl_pkg::ALU_SUB: begin
				res = a - bb;
				wide = longint'($signed(a)) - longint'($signed(bb));
				ovf = b.is_signed && (wide > MAX_S || wide < MIN_S);
			end
			exe_ctrl_pkg::ALU_AND: res = a & bb;
			exe_ctrl_pkg::ALU_OR: res = a | bb;
			exe_ctrl_pkg::ALU_XOR: res = a ^ bb;
			exe_ctrl_pkg::ALU_NOR: res = ~(a | bb);
			exe_ctrl_pkg::ALU_SLT: begin
				res = b.is_signed ? 32'($signed(a) < $signed(bb)) : 32'(a < bb);
			end
			exe_ctrl_pkg::ALU_LUI: res = {bb[15:0], 16'h0000};
			exe_ctrl_pkg::ALU_SLL: res = bb << sh;
			exe_ctrl_pkg::ALU_SRL: res = bb >> sh;
			exe_ctrl_pkg::ALU_SRA: res = (bb >> sh) | (bb[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			default: res = '0;
		endcase
		o.valid = b.valid;
		o.result = res;
		o.store_data = b.data_rt;
		o.overflow = ovf;
		o.regw_addr = b.regw_addr;
		o.wb_wen = b.wb_wen && !ovf;
		return o;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("error %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic compare_outputs();
		check_value("valid", exe_out.valid, expected.valid);
		check_value("result", exe_out.result, expected.result);
		check_value("store_data", exe_out.store_data, expected.store_data);
		check_value("overflow", exe_out.overflow, expected.overflow);
		check_value("regw_addr", exe_out.regw_addr, expected.regw_addr);
		check_value("wb_wen", exe_out.wb_wen, expected.wb_wen);
		check_value("wb_wen_with_overflow", exe_out.wb_wen & exe_out.overflow, 0);
	endtask

	// one edge then model update and compare
	task automatic step_cycle();
		@(posedge clk);
		if (exe_rst) begin
			expected = '0;
		end
		else if (exe_en) begin
			expected = model_out(id_in);
		end
		#1;
		compare_outputs();
	endtask

	task automatic run_phase(input int mode, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			id_in = make_bundle(mode);
			exe_en = (mode == 3) ? (rand_bits(2) != 0) : 1'b1;  // stall about a quarter
			step_cycle();
		end
	endtask

	task automatic pulse_reset();
		exe_rst = 1'b1;
		for (int i = 0; i < MID_RST_CYCLES; i++) begin
			id_in = make_bundle(1);
			exe_en = 1'b1;
			step_cycle();
		end
		exe_rst = 1'b0;
	endtask

	initial begin
		exe_rst = 1'b1;
		exe_en = 1'b0;
		id_in = '0;
		expected = '0;
		repeat (RST_CYCLES) step_cycle();
		exe_rst = 1'b0;
		run_phase(0, ALU_CYCLES);
		pulse_reset();
		run_phase(1, SRC_CYCLES);
		run_phase(2, OVF_CYCLES);
		pulse_reset();
		run_phase(3, STALL_CYCLES);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#((RST_CYCLES + TEST_CYCLES + 20) * 8);
		$display("watchdog expired before the tests finished");
		$display("checks %0d errors %0d", checks, errors);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+hw
hw/exe_ctrl_pkg.sv
hw/exe_data_pkg.sv
hw/operand_select.sv
hw/alu_core.sv
hw/shift_unit.sv
hw/exe_result.sv
hw/exe_stage.sv
tb/exe_stage_tb.sv
